// ==== sources.f ====
+incdir+hdl
hdl/sb_pkg.sv
hdl/sb_ifs.sv
hdl/sb_dispatch.sv
hdl/sb_issue.sv
hdl/sb_regfile.sv
hdl/sb_exec.sv
hdl/sb_writeback.sv
hdl/sb_top.sv
sim/sb_assertions.sv
sim/sb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the scoreboard testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module sb_tb -Mdir obj_dir \
    && ./obj_dir/Vsb_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// ==== sim/sb_tb.sv ====
// testbench for the scoreboard core with random words checked by a sequential model
// every retirement is compared in per register order, then all registers are read back
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_tb import sb_pkg::*; ();

    localparam int N_RAND  = 60;
    localparam int N_WORDS = 3 * N_RAND + 8;
    localparam int N_READS = 2 * `SB_NREGS;
    // 20 cycles of 4 ns per bus transfer plus reset and drain margin
    localparam int WATCHDOG_NS = (N_WORDS + N_READS) * 20 * 4 + 400;

    logic    CLK, nRST, cyc, stb, we, ack, ret_valid, busy;
    regsel_t adr, ret_reg;
    word_t   dat_w, dat_r, ret_data;

    // architectural state in program order
    word_t       model_rf [`SB_NREGS];
    // values still to retire, one queue per destination
    word_t       exp_q [`SB_NREGS][$];
    logic [31:0] rng;
    int          errors, checks, retired;
    string       test_name;

    sb_top dut (
        .CLK, .nRST, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .ret_valid, .ret_reg, .ret_data, .busy
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ldi packs a 10 bit immediate where the source fields would sit
    function automatic word_t encode(input opcode_e op, input regsel_t rd, input regsel_t rs1,
                                     input regsel_t rs2, input logic [9:0] imm);
        if (op == LDI) return {op, rd, imm};
        return {op, rd, rs1, rs2, imm[3:0]};
    endfunction

    // result of one word on the sequential machine
    function automatic word_t model_exec(input word_t w, input word_t a, input word_t b);
        case (opcode_e'(w[15:13]))
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            XOR: return a ^ b;
            LDI: return {6'd0, w[9:0]};
            MUL: return a * b;
            default: return '0;
        endcase
    endfunction

    // mode 0 alu only, mode 1 raw chains, mode 2 crowded r0 to r2
    function automatic word_t gen_word(input int mode, input logic [31:0] r, input regsel_t prev);
        opcode_e op;
        regsel_t rd, rs1, rs2;
        op  = opcode_e'(3'(r[7:0] % 8'd5));
        rd  = r[10:8];
        rs1 = r[13:11];
        rs2 = r[16:14];
        if (mode == 1) begin
            op  = r[17] ? MUL : opcode_e'({1'b0, r[1:0]});
            if (r[20:18] == 3'd0) op = LDI;
            rs1 = prev;
        end else if (mode == 2) begin
            op  = opcode_e'(3'(r[7:0] % 8'd6));
            rd  = regsel_t'(r[9:8] % 2'd3);
            rs1 = regsel_t'(r[12:11] % 2'd3);
            rs2 = regsel_t'(r[15:14] % 2'd3);
        end
        return encode(op, rd, rs1, rs2, r[31:22]);
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    // bus stays driven after ack, the next transfer or idle replaces it
    task automatic wb_write(input word_t w);
        word_t v;
        @(negedge CLK);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        dat_w = w;
        @(posedge CLK);
        while (!ack) @(posedge CLK);
        // ack order is program order
        v = model_exec(w, model_rf[w[9:7]], model_rf[w[6:4]]);
        model_rf[w[12:10]] = v;
        exp_q[w[12:10]].push_back(v);
    endtask

    task automatic wb_read(input regsel_t r, output word_t d);
        @(negedge CLK);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = r;
        @(posedge CLK);
        while (!ack) @(posedge CLK);
        d = dat_r;
    endtask

    task automatic bus_idle();
        @(negedge CLK);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic run_random(input string name, input int mode);
        word_t w;
        test_name = name;
        w = '0;
        for (int i = 0; i < N_RAND; i++) begin
            rng = xorshift(rng);
            w = gen_word(mode, rng, w[12:10]);
            wb_write(w);
            // occasional gap so dispatch timing varies
            if (rng[21:20] == 2'd0) bus_idle();
        end
        bus_idle();
    endtask

    // compare every retirement with the oldest expected value of its register
    always @(posedge CLK) begin
        word_t exp_v;
        if (nRST && ret_valid) begin
            retired++;
            if (exp_q[ret_reg].size() == 0) begin
                errors++;
                $display("retirement to r%0d with data %h that no accepted word explains",
                         ret_reg, ret_data);
            end else begin
                exp_v = exp_q[ret_reg].pop_front();
                check_value($sformatf("%s r%0d", test_name, ret_reg), exp_v, ret_data);
            end
        end
    end

    initial begin
        word_t rd_v;
        nRST  = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        rng   = 32'd47758;
        errors  = 0;
        checks  = 0;
        retired = 0;
        test_name = "reset";
        for (int r = 0; r < `SB_NREGS; r++) model_rf[r] = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // reset state and register contents
        check_value("reset busy", '0, word_t'(busy));
        check_value("reset ack", '0, word_t'(ack));
        for (int r = 0; r < `SB_NREGS; r++) begin
            wb_read(regsel_t'(r), rd_v);
            check_value($sformatf("reset read r%0d", r), '0, rd_v);
        end
        bus_idle();

        run_random("alu ops", 0);
        run_random("raw chains", 1);

        // mul result feeds a waiting alu row while later words rewrite its sources
        test_name = "war and waw";
        wb_write(encode(LDI, 3'd2, 3'd0, 3'd0, 10'd5));
        wb_write(encode(LDI, 3'd3, 3'd0, 3'd0, 10'd7));
        wb_write(encode(MUL, 3'd1, 3'd2, 3'd3, 10'd0));
        wb_write(encode(ADD, 3'd4, 3'd1, 3'd5, 10'd0));
        wb_write(encode(LDI, 3'd5, 3'd0, 3'd0, 10'd9));
        wb_write(encode(MUL, 3'd6, 3'd4, 3'd5, 10'd0));
        wb_write(encode(SUB, 3'd5, 3'd6, 3'd1, 10'd0));
        wb_write(encode(XOR, 3'd2, 3'd2, 3'd6, 10'd0));
        bus_idle();
        run_random("hazards", 2);

        // drain, then compare the whole register file
        @(posedge CLK);
        while (busy) @(posedge CLK);
        test_name = "final state";
        for (int r = 0; r < `SB_NREGS; r++) begin
            wb_read(regsel_t'(r), rd_v);
            check_value($sformatf("final read r%0d", r), model_rf[r], rd_v);
        end
        bus_idle();
        for (int r = 0; r < `SB_NREGS; r++) begin
            if (exp_q[r].size() != 0) begin
                errors++;
                $display("r%0d still has %0d accepted results that never retired",
                         r, exp_q[r].size());
            end
        end

        $display("checks %0d retired %0d errors %0d", checks, retired, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sim/sb_assertions.sv ====
// protocol and pipeline properties of the scoreboard core
// bound into every sb_top instance and sampled on the rising clock
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_assertions (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  cyc,
    input logic                  stb,
    input logic                  ack,
    input logic                  ret_valid,
    input logic [`SB_NUNITS-1:0] issue_en
);

    // ack only answers a live wishbone cycle
    ack_needs_req: assert property (@(posedge CLK) disable iff (!nRST) ack |-> (cyc && stb))
        else $error("ack high without cyc and stb");

    // single issue per cycle
    one_issue: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(issue_en))
        else $error("more than one fust row issued in a cycle");

    // no retirement while reset holds
    quiet_reset: assert property (@(posedge CLK) !nRST |-> !ret_valid)
        else $error("ret_valid high during reset");

endmodule

bind sb_top sb_assertions u_assertions (
    .CLK(CLK), .nRST(nRST), .cyc(cyc), .stb(stb), .ack(ack),
    .ret_valid(ret_valid), .issue_en(issue_en)
);

// ==== hdl/sb_top.sv ====
// scoreboard core top with a wishbone slave for instructions and register reads
// ret_* mirror every retirement and busy stays high until all work drains
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_top import sb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  regsel_t adr,
    input  word_t   dat_w,
    output word_t   dat_r,
    output logic    ack,
    output logic    ret_valid,
    output regsel_t ret_reg,
    output word_t   ret_data,
    output logic    busy
);

    fust_wr_if fw ();
    result_if  res ();

    regsel_t rsel1, rsel2, hsel, iss_rd, alu_rd, mul_rd;
    word_t   rdat1, rdat2, rdata, iss_imm, alu_res, mul_res;
    opcode_e iss_op;
    logic [`SB_NUNITS-1:0] issue_en, done, hold, ack_unit;
    logic row_active;
    logic pending;

    sb_dispatch u_dispatch (
        .CLK, .nRST, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .fw(fw.disp), .res(res.snoop), .rdata, .hsel
    );

    sb_issue u_issue (
        .CLK, .nRST, .fw(fw.iss), .res(res.snoop), .rsel1, .rsel2,
        .issue_en, .iss_op, .iss_rd, .iss_imm, .done, .hold, .row_active
    );

    sb_regfile u_regfile (
        .CLK, .nRST, .res(res.snoop), .rsel1, .rsel2, .hsel, .rdat1, .rdat2, .rdata
    );

    sb_exec u_exec (
        .CLK, .nRST, .issue_en, .iss_op, .iss_rd, .iss_imm, .rdat1, .rdat2, .hold,
        .done, .alu_res, .mul_res, .alu_rd, .mul_rd, .ack_unit, .pending
    );

    sb_writeback u_writeback (
        .done, .hold, .alu_res, .mul_res, .alu_rd, .mul_rd, .ack_unit, .res(res.wb)
    );

    assign ret_valid = res.valid;
    assign ret_reg   = res.rd;
    assign ret_data  = res.data;
    // rows still occupied or exec still holding a result
    assign busy = row_active | pending;

endmodule

// ==== hdl/sb_writeback.sv ====
// result stage picking one finished unit per cycle
// the pick drives the regfile write and the tag broadcast
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_writeback import sb_pkg::*; (
    input  logic [`SB_NUNITS-1:0] done,
    input  logic [`SB_NUNITS-1:0] hold,
    input  word_t                 alu_res,
    input  word_t                 mul_res,
    input  regsel_t               alu_rd,
    input  regsel_t               mul_rd,
    output logic [`SB_NUNITS-1:0] ack_unit,
    result_if.wb                  res
);

    logic [`SB_NUNITS-1:0] cand;

    // units waiting on a war hold sit out
    assign cand = done & ~hold;

    // mul goes first and the alu waits a cycle
    assign ack_unit[UNIT_MUL] = cand[UNIT_MUL];
    assign ack_unit[UNIT_ALU] = cand[UNIT_ALU] & ~cand[UNIT_MUL];

    assign res.valid = |cand;
    assign res.tag   = cand[UNIT_MUL] ? TAG_MUL : TAG_ALU;
    assign res.rd    = cand[UNIT_MUL] ? mul_rd : alu_rd;
    assign res.data  = cand[UNIT_MUL] ? mul_res : alu_res;

endmodule

// ==== hdl/sb_exec.sv ====
// execute datapath with a single cycle alu and a pipelined multiplier
// each unit keeps its result until writeback takes it
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_exec import sb_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic [`SB_NUNITS-1:0] issue_en,
    input  opcode_e               iss_op,
    input  regsel_t               iss_rd,
    input  word_t                 iss_imm,
    input  word_t                 rdat1,
    input  word_t                 rdat2,
    input  logic [`SB_NUNITS-1:0] hold,
    output logic [`SB_NUNITS-1:0] done,
    output word_t                 alu_res,
    output word_t                 mul_res,
    output regsel_t               alu_rd,
    output regsel_t               mul_rd,
    input  logic [`SB_NUNITS-1:0] ack_unit,
    output logic                  pending
);

    logic alu_v;
    // stage 0 holds operands and the last stage is the hold register
    logic [`SB_MUL_LAT-1:0] mul_v;
    word_t   mul_a;
    word_t   mul_b;
    word_t   mul_p   [1:`SB_MUL_LAT-2];
    regsel_t mul_rdp [0:`SB_MUL_LAT-2];
    logic alu_ack;
    logic mul_ack;

    // a held unit keeps its result
    assign alu_ack = ack_unit[UNIT_ALU] & ~hold[UNIT_ALU];
    assign mul_ack = ack_unit[UNIT_MUL] & ~hold[UNIT_MUL];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            if (issue_en[UNIT_ALU]) alu_v <= 1'b1;
            else if (alu_ack) alu_v <= 1'b0;
            mul_v[0] <= issue_en[UNIT_MUL];
            for (int s = 1; s < `SB_MUL_LAT - 1; s++) begin
                mul_v[s] <= mul_v[s-1];
            end
            if (mul_v[`SB_MUL_LAT-2]) mul_v[`SB_MUL_LAT-1] <= 1'b1;
            else if (mul_ack) mul_v[`SB_MUL_LAT-1] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_en[UNIT_ALU]) begin
            alu_rd <= iss_rd;
            case (iss_op)
                ADD:     alu_res <= rdat1 + rdat2;
                SUB:     alu_res <= rdat1 - rdat2;
                AND:     alu_res <= rdat1 & rdat2;
                XOR:     alu_res <= rdat1 ^ rdat2;
                LDI:     alu_res <= iss_imm;
                // unused opcodes give zero
                default: alu_res <= '0;
            endcase
        end
        if (issue_en[UNIT_MUL]) begin
            mul_a      <= rdat1;
            mul_b      <= rdat2;
            mul_rdp[0] <= iss_rd;
        end
        // low half of the product
        mul_p[1]   <= mul_a * mul_b;
        mul_rdp[1] <= mul_rdp[0];
        for (int s = 2; s <= `SB_MUL_LAT - 2; s++) begin
            mul_p[s]   <= mul_p[s-1];
            mul_rdp[s] <= mul_rdp[s-1];
        end
        if (mul_v[`SB_MUL_LAT-2]) begin
            mul_res <= mul_p[`SB_MUL_LAT-2];
            mul_rd  <= mul_rdp[`SB_MUL_LAT-2];
        end
    end

    assign done[UNIT_ALU] = alu_v;
    assign done[UNIT_MUL] = mul_v[`SB_MUL_LAT-1];
    assign pending = alu_v | (|mul_v);

endmodule

// ==== hdl/sb_regfile.sv ====
// eight entry register file written by the result broadcast
// two operand read ports for issue and one for host reads
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_regfile import sb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    result_if.snoop res,
    input  regsel_t rsel1,
    input  regsel_t rsel2,
    input  regsel_t hsel,
    output word_t   rdat1,
    output word_t   rdat2,
    output word_t   rdata
);

    word_t regs [`SB_NREGS];

    // all registers read 0 after reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < `SB_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (res.valid) begin
            regs[res.rd] <= res.data;
        end
    end

    // reads see the old value during a write cycle
    assign rdat1 = regs[rsel1];
    assign rdat2 = regs[rsel2];
    assign rdata = regs[hsel];

endmodule

// ==== hdl/sb_issue.sv ====
// execute control with one fust row per unit
// tracks row states and ages, issues the oldest ready row and holds results on war
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_issue import sb_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    fust_wr_if.iss                fw,
    result_if.snoop               res,
    output regsel_t               rsel1,
    output regsel_t               rsel2,
    output logic [`SB_NUNITS-1:0] issue_en,
    output opcode_e               iss_op,
    output regsel_t               iss_rd,
    output word_t                 iss_imm,
    input  logic [`SB_NUNITS-1:0] done,
    output logic [`SB_NUNITS-1:0] hold,
    output logic                  row_active
);

    fust_state_e state [`SB_NUNITS];
    opcode_e     op    [`SB_NUNITS];
    regsel_t     rd    [`SB_NUNITS];
    regsel_t     rs1   [`SB_NUNITS];
    regsel_t     rs2   [`SB_NUNITS];
    word_t       imm   [`SB_NUNITS];
    tag_t        t1    [`SB_NUNITS];
    tag_t        t2    [`SB_NUNITS];
    age_t        age   [`SB_NUNITS];
    logic [`SB_NUNITS-1:0] wr;
    logic [`SB_NUNITS-1:0] rdy;
    logic [`SB_NUNITS-1:0] retire;
    logic [`SB_NUNITS-1:0] war;
    logic sel;

    always_comb begin
        for (int i = 0; i < `SB_NUNITS; i++) begin
            wr[i]      = fw.en && (fw.unit == 1'(i));
            rdy[i]     = (state[i] == RDY);
            retire[i]  = res.valid && (res.tag == tag_t'(i + 1));
            // busy drops on the edge after retirement
            fw.busy[i] = (state[i] != EMPTY);
        end
    end

    assign row_active = |fw.busy;

    // oldest ready row goes and mul takes a tie
    assign issue_en[UNIT_MUL] = rdy[UNIT_MUL] &
                                (~rdy[UNIT_ALU] | (age[UNIT_MUL] >= age[UNIT_ALU]));
    assign issue_en[UNIT_ALU] = rdy[UNIT_ALU] & ~issue_en[UNIT_MUL];
    assign sel = issue_en[UNIT_MUL];

    // operand select for the regfile and the exec latch
    assign rsel1   = rs1[sel];
    assign rsel2   = rs2[sel];
    assign iss_op  = op[sel];
    assign iss_rd  = rd[sel];
    assign iss_imm = imm[sel];

    // war check against the other row
    // a tag of zero on a matching source means it still wants the old value
    // a row issuing this cycle already read the regfile
    always_comb begin
        for (int i = 0; i < `SB_NUNITS; i++) begin
            war[i] = (state[1-i] == WAIT || state[1-i] == RDY) && !issue_en[1-i] &&
                     (op[1-i] != LDI) && (age[1-i] > age[i]) &&
                     ((rs1[1-i] == rd[i] && t1[1-i] == TAG_NONE) ||
                      (rs2[1-i] == rd[i] && t2[1-i] == TAG_NONE));
        end
    end

    assign hold = done & war;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `SB_NUNITS; i++) begin
                state[i] <= EMPTY;
                age[i]   <= '0;
                t1[i]    <= TAG_NONE;
                t2[i]    <= TAG_NONE;
            end
        end else begin
            for (int i = 0; i < `SB_NUNITS; i++) begin
                case (state[i])
                    EMPTY: if (wr[i]) state[i] <= WAIT;
                    // ready one cycle after both tags clear
                    WAIT: if (t1[i] == TAG_NONE && t2[i] == TAG_NONE) state[i] <= RDY;
                    RDY: if (issue_en[i]) state[i] <= EX;
                    EX: if (retire[i]) state[i] <= EMPTY;
                endcase
                // new rows start at 1 and age saturates while unissued
                if (wr[i]) begin
                    age[i] <= age_t'(1);
                end else if (state[i] == WAIT || state[i] == RDY) begin
                    if (age[i] != '1) age[i] <= age[i] + 1'b1;
                end else begin
                    age[i] <= '0;
                end
                // wakeup on the result broadcast
                if (wr[i]) begin
                    t1[i] <= fw.t1;
                    t2[i] <= fw.t2;
                end else begin
                    if (res.valid && t1[i] == res.tag) t1[i] <= TAG_NONE;
                    if (res.valid && t2[i] == res.tag) t2[i] <= TAG_NONE;
                end
            end
        end
    end

    // row payload
    always_ff @(posedge CLK) begin
        for (int i = 0; i < `SB_NUNITS; i++) begin
            if (wr[i]) begin
                op[i]  <= fw.op;
                rd[i]  <= fw.rd;
                rs1[i] <= fw.rs1;
                rs2[i] <= fw.rs2;
                imm[i] <= fw.imm;
            end
        end
    end

endmodule

// ==== hdl/sb_dispatch.sv ====
// decode stage with the wishbone slave and the register status table
// accepted words go into a fust row and host reads come back from the regfile
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_dispatch import sb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  regsel_t adr,
    input  word_t   dat_w,
    output word_t   dat_r,
    output logic    ack,
    fust_wr_if.disp fw,
    result_if.snoop res,
    input  word_t   rdata,
    output regsel_t hsel
);

    // tag of the pending producer for every register
    tag_t [`SB_NREGS-1:0] reg_stat;
    opcode_e op;
    regsel_t rd;
    regsel_t rs1;
    regsel_t rs2;
    logic    unit;
    logic    req;
    logic    accept;
    tag_t    t1_raw;
    tag_t    t2_raw;

    // the ack cycle closes a request so it is never seen twice
    assign req = cyc & stb & ~ack;

    // field split of the instruction word
    assign op   = opcode_e'(dat_w[15:13]);
    assign rd   = dat_w[12:10];
    assign rs1  = dat_w[9:7];
    assign rs2  = dat_w[6:4];
    assign unit = (op == MUL);

    // structural hazard on the row and waw hazard on rd both stall
    assign accept = req & we & ~fw.busy[unit] & (reg_stat[rd] == TAG_NONE);

    assign t1_raw = reg_stat[rs1];
    assign t2_raw = reg_stat[rs2];

    assign fw.en   = accept;
    assign fw.unit = unit;
    assign fw.op   = op;
    assign fw.rd   = rd;
    assign fw.rs1  = rs1;
    assign fw.rs2  = rs2;
    assign fw.imm  = {{(`SB_DATA_W-10){1'b0}}, dat_w[9:0]};
    // ldi reads nothing
    // a producer retiring right now counts as done
    assign fw.t1 = (op == LDI || (res.valid && t1_raw == res.tag)) ? TAG_NONE : t1_raw;
    assign fw.t2 = (op == LDI || (res.valid && t2_raw == res.tag)) ? TAG_NONE : t2_raw;

    // host read port of the regfile
    assign hsel = adr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack      <= 1'b0;
            reg_stat <= '0;
        end else begin
            ack <= accept | (req & ~we);
            // clear only if the entry still names the retiring unit
            if (res.valid && reg_stat[res.rd] == res.tag) begin
                reg_stat[res.rd] <= TAG_NONE;
            end
            // a new producer wins over a clear on the same edge
            if (accept) begin
                reg_stat[rd] <= unit ? TAG_MUL : TAG_ALU;
            end
        end
    end

    // read data ignores pending writes
    always_ff @(posedge CLK) begin
        if (req & ~we) begin
            dat_r <= rdata;
        end
    end

endmodule

// ==== hdl/sb_ifs.sv ====
// links between the internal blocks of the scoreboard core
// fust_wr_if fills a fust row and result_if broadcasts one retirement per cycle
`timescale 1ns/1ps
`include "sb_macros.svh"

// dispatch to issue
interface fust_wr_if import sb_pkg::*; ();
    // write strobe for the selected row
    logic    en;
    // row select where 0 is alu and 1 is mul
    logic    unit;
    opcode_e op;
    regsel_t rd;
    regsel_t rs1;
    regsel_t rs2;
    word_t   imm;
    // source tags after the same cycle result bypass
    tag_t    t1;
    tag_t    t2;
    // row occupied, from issue
    logic [`SB_NUNITS-1:0] busy;

    modport disp (
        output en, unit, op, rd, rs1, rs2, imm, t1, t2,
        input  busy
    );
    modport iss (
        input  en, unit, op, rd, rs1, rs2, imm, t1, t2,
        output busy
    );
endinterface

// writeback broadcast seen by issue, dispatch and the regfile
interface result_if import sb_pkg::*; ();
    logic    valid;
    tag_t    tag;
    regsel_t rd;
    word_t   data;

    modport wb    (output valid, tag, rd, data);
    modport snoop (input  valid, tag, rd, data);
endinterface

// ==== hdl/sb_pkg.sv ====
// types and encodings shared by every block of the scoreboard core
// modules take them in with import sb_pkg::* in their header
`include "sb_macros.svh"

package sb_pkg;

    typedef logic [`SB_DATA_W-1:0] word_t;
    typedef logic [`SB_REG_W-1:0]  regsel_t;
    typedef logic [`SB_AGE_W-1:0]  age_t;

    // 0 means the value sits in the regfile
    // otherwise it is the producing unit index plus one
    typedef logic [$clog2(`SB_NUNITS+1)-1:0] tag_t;

    localparam tag_t TAG_NONE = tag_t'(0);
    localparam tag_t TAG_ALU  = tag_t'(1);
    localparam tag_t TAG_MUL  = tag_t'(2);

    // bit position of each unit in per unit vectors
    localparam int UNIT_ALU = 0;
    localparam int UNIT_MUL = 1;

    // opcode sits in bits 15:13
    // rd in 12:10 and rs1 in 9:7 and rs2 in 6:4
    // ldi zero extends bits 9:0 as its immediate
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        XOR = 3'd3,
        LDI = 3'd4,
        MUL = 3'd5
    } opcode_e;

    typedef enum logic [1:0] {EMPTY, WAIT, RDY, EX} fust_state_e;

endpackage

// ==== hdl/sb_macros.svh ====
// widths and latencies shared by the scoreboard core
// include this wherever an SB_ macro appears
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// register data and instruction word width
`define SB_DATA_W 16

// register file depth and index width
`define SB_NREGS 8
`define SB_REG_W 3

// one fust row per functional unit (alu and mul)
`define SB_NUNITS 2

// mul result is ready this many edges after issue
`define SB_MUL_LAT 3

// saturating age counter width of a fust row
`define SB_AGE_W 2

`endif
